/* project.f */
+incdir+include
hdl/board_pkg.sv
hdl/pin_router.sv
hdl/i2c_bus_fabric.sv
hdl/cheri_err_monitor.sv
hdl/board_harness_top.sv
test/tb_board_harness.sv

/* run_sim.sh */
#!/bin/sh
# Builds the board harness testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_board_harness -Mdir build

./build/Vtb_board_harness | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed."
else
  echo "Simulation failed."
  exit 1
fi

/* test/tb_board_harness.sv */
////////////////////////////////////////
// Self-checking testbench for the board pin harness.
// Applies a table of rows and checks every DUT output each cycle.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "board_config.svh"

module tb_board_harness;

  // One table row holds every DUT input for one cycle.
  typedef struct packed {
    board_pkg::out_pins_t   out;
    board_pkg::inout_pins_t io;
    board_pkg::inout_pins_t en;
    logic                   tx_en, rx_en, uart_rx, line_rx, flash_cipo, pmod_cipo;
    board_pkg::i2c_lines_t  scl_dev, sda_dev;
    board_pkg::cheri_err_t  err;
  } vec_t;

  logic clk_i, rst_ni;
  logic rs485_tx_enable_i, rs485_rx_enable_i, uart_rx_i, rs485_line_rx_i;
  logic flash_cipo_i, pmod_cipo_i;
  logic uart_tx_o, rs485_line_tx_o, flash_sck_o, flash_cs_o, flash_copi_o;
  logic pmod_sck_o, pmod_cs_o, pmod_copi_o;
  board_pkg::out_pins_t   out_to_pins_i;
  board_pkg::inout_pins_t inout_to_pins_i, inout_to_pins_en_i, inout_from_pins_o;
  board_pkg::in_pins_t    in_from_pins_o;
  board_pkg::i2c_lines_t  i2c_scl_dev_i, i2c_sda_dev_i, i2c_scl_o, i2c_sda_o;
  board_pkg::cheri_err_t  cheri_err_i, cheri_seen_o, cheri_new_o;

  // Stimulus table with the test number of each row.
  vec_t        vec_q [$];
  int          grp_q [$];
  int          grp_vecs [];
  int          grp_errs [];
  int          checks = 0, errors = 0, cur_grp = 0;
  int          cycle_count = 0, cycle_limit = 50;
  logic [31:0] lcg_state;

  board_harness_top board_harness_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Run length guard.
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the table did not finish.", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Takes the upper LCG bits, since the low ones repeat too soon.
  function automatic vec_t rand_vec();
    vec_t v;
    logic [31:0] r;
    r = next_rand();
    v.out = r[31 -: `BOARD_OUT_PINS];
    r = next_rand();
    v.io = r[31 -: `BOARD_INOUT_PINS];
    r = next_rand();
    v.en = r[31 -: `BOARD_INOUT_PINS];
    r = next_rand();
    {v.tx_en, v.rx_en, v.uart_rx, v.line_rx, v.flash_cipo, v.pmod_cipo} = r[31:26];
    v.scl_dev = r[25:23];
    v.sda_dev = r[22:20];
    v.err = '0;
    return v;
  endfunction

  // Controller side of each bus, high wherever the line is released.
  function automatic board_pkg::i2c_lines_t scl_line(input vec_t v);
    board_pkg::i2c_lines_t drv, en;
    drv = {v.io[`INOUT_PIN_SCL1], v.io[`INOUT_PIN_RPH_G3_SCL], v.io[`INOUT_PIN_RPH_G1]};
    en  = {v.en[`INOUT_PIN_SCL1], v.en[`INOUT_PIN_RPH_G3_SCL], v.en[`INOUT_PIN_RPH_G1]};
    return ~(en & ~drv);
  endfunction

  function automatic board_pkg::i2c_lines_t sda_line(input vec_t v);
    board_pkg::i2c_lines_t drv, en;
    drv = {v.io[`INOUT_PIN_SDA1], v.io[`INOUT_PIN_RPH_G2_SDA], v.io[`INOUT_PIN_RPH_G0]};
    en  = {v.en[`INOUT_PIN_SDA1], v.en[`INOUT_PIN_RPH_G2_SDA], v.en[`INOUT_PIN_RPH_G0]};
    return ~(en & ~drv);
  endfunction

  // Loopback destinations come from the previous row p.
  function automatic board_pkg::in_pins_t exp_in_rd(input vec_t v, input vec_t p);
    board_pkg::in_pins_t r;
    r = '0;
    r[`IN_PIN_SER0_RX]     = v.uart_rx;
    r[`IN_PIN_RS485_RX]    = v.rx_en & v.line_rx;
    r[`IN_PIN_APPSPI_CIPO] = v.flash_cipo;
    r[`IN_PIN_MB8]         = p.out[`OUT_PIN_MB7];
    r[`IN_PIN_MB3]         = p.out[`OUT_PIN_MB4];
    return r;
  endfunction

  function automatic board_pkg::inout_pins_t exp_inout_rd(input vec_t v, input vec_t p);
    board_pkg::inout_pins_t r;
    board_pkg::i2c_lines_t  scl, sda;
    // Wired AND of controller and devices.
    scl = scl_line(v) & v.scl_dev;
    sda = sda_line(v) & v.sda_dev;
    r = '0;
    r[`INOUT_PIN_RPH_G1]     = scl[`I2C_BUS_HAT_ID];
    r[`INOUT_PIN_RPH_G0]     = sda[`I2C_BUS_HAT_ID];
    r[`INOUT_PIN_RPH_G3_SCL] = scl[`I2C_BUS_HAT_SEC];
    r[`INOUT_PIN_RPH_G2_SDA] = sda[`I2C_BUS_HAT_SEC];
    r[`INOUT_PIN_SCL1]       = scl[`I2C_BUS_QWIIC1];
    r[`INOUT_PIN_SDA1]       = sda[`I2C_BUS_QWIIC1];
    {r[`INOUT_PIN_SCL0], r[`INOUT_PIN_SDA0], r[`INOUT_PIN_MB5], r[`INOUT_PIN_MB6]} = 4'hf;
    r[`INOUT_PIN_PMOD1_3]   = v.pmod_cipo;
    r[`INOUT_PIN_AH_TMPIO9] = p.io[`INOUT_PIN_AH_TMPIO8];
    r[`INOUT_PIN_AH_TMPIO0] = p.io[`INOUT_PIN_AH_TMPIO1];
    r[`INOUT_PIN_PMOD0_1]   = p.out[`OUT_PIN_MB10];
    return r;
  endfunction

  function automatic string test_name(input int g);
    case (g)
      0: return "I2C resolution";
      1: return "SPI routing";
      2: return "UART and RS485";
      3: return "Loopback";
      default: return "First CHERI occurrence";
    endcase
  endfunction

  task automatic add_row(input vec_t v, input int g);
    vec_q.push_back(v);
    grp_q.push_back(g);
  endtask

  task automatic add_cheri_row(input board_pkg::cheri_err_t e);
    vec_t v;
    v = rand_vec();
    v.err = e;
    add_row(v, 4);
  endtask

  task automatic build_table();
    vec_t v;
    logic [2:0] k0, k1, k2;
    lcg_state = 32'd54290;
    grp_vecs = new[5];
    grp_errs = new[5];
    // Each bus runs through all eight drive, enable and pull-down codes on its own phase.
    for (int c = 0; c < 8; c++) begin
      v = rand_vec();
      k0 = c[2:0];
      k1 = k0 + 3'd3;
      k2 = k0 + 3'd6;
      {v.io[`INOUT_PIN_SCL1], v.io[`INOUT_PIN_RPH_G3_SCL], v.io[`INOUT_PIN_RPH_G1]} =
        {k2[0], k1[0], k0[0]};
      {v.en[`INOUT_PIN_SCL1], v.en[`INOUT_PIN_RPH_G3_SCL], v.en[`INOUT_PIN_RPH_G1]} =
        {k2[1], k1[1], k0[1]};
      {v.io[`INOUT_PIN_SDA1], v.io[`INOUT_PIN_RPH_G2_SDA], v.io[`INOUT_PIN_RPH_G0]} =
        ~{k2[0], k1[0], k0[0]};
      {v.en[`INOUT_PIN_SDA1], v.en[`INOUT_PIN_RPH_G2_SDA], v.en[`INOUT_PIN_RPH_G0]} =
        ~{k2[1], k1[1], k0[1]};
      v.scl_dev = {k2[2], k1[2], k0[2]};
      v.sda_dev = ~{k2[2], k1[2], k0[2]};
      add_row(v, 0);
    end
    for (int n = 0; n < 16; n++)
      add_row(rand_vec(), 1);
    // All four RS485 enable pairs, four rows each.
    for (int e = 0; e < 16; e++) begin
      v = rand_vec();
      v.tx_en = e[1];
      v.rx_en = e[0];
      add_row(v, 2);
    end
    for (int n = 0; n < 16; n++)
      add_row(rand_vec(), 3);
    // Raise, drop and raise again.
    add_cheri_row(9'h001);
    add_cheri_row(9'h000);
    add_cheri_row(9'h001);
    add_cheri_row(9'h003);
    add_cheri_row(9'h002);
    add_cheri_row(9'h000);
    add_cheri_row(9'h0f0);
    add_cheri_row(9'h1f0);
    add_cheri_row(9'h100);
    add_cheri_row(9'h000);
    add_cheri_row(9'h1ff);
    add_cheri_row(9'h1ff);
  endtask

  task automatic apply_vec(input vec_t v);
    out_to_pins_i      = v.out;
    inout_to_pins_i    = v.io;
    inout_to_pins_en_i = v.en;
    rs485_tx_enable_i  = v.tx_en;
    rs485_rx_enable_i  = v.rx_en;
    uart_rx_i          = v.uart_rx;
    rs485_line_rx_i    = v.line_rx;
    flash_cipo_i       = v.flash_cipo;
    pmod_cipo_i        = v.pmod_cipo;
    i2c_scl_dev_i      = v.scl_dev;
    i2c_sda_dev_i      = v.sda_dev;
    cheri_err_i        = v.err;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks = checks + 1;
    assert (act === exp) else begin
      $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      errors = errors + 1;
      grp_errs[cur_grp] = grp_errs[cur_grp] + 1;
    end
  endtask

  task automatic check_vec(input vec_t v, input vec_t p, input board_pkg::cheri_err_t seen,
                           input board_pkg::cheri_err_t fresh);
    check_value("uart_tx_o", 32'(v.out[`OUT_PIN_SER0_TX]), 32'(uart_tx_o));
    check_value("rs485_line_tx_o", 32'(v.tx_en ? v.out[`OUT_PIN_RS485_TX] : 1'b1),
                32'(rs485_line_tx_o));
    check_value("flash_sck_o", 32'(v.out[`OUT_PIN_APPSPI_SCK]), 32'(flash_sck_o));
    check_value("flash_cs_o", 32'(v.out[`OUT_PIN_APPSPI_CS]), 32'(flash_cs_o));
    check_value("flash_copi_o", 32'(v.out[`OUT_PIN_APPSPI_COPI]), 32'(flash_copi_o));
    // PMOD lines float high unless enabled.
    check_value("pmod_cs_o", 32'(v.en[`INOUT_PIN_PMOD1_1] ? v.io[`INOUT_PIN_PMOD1_1] : 1'b1),
                32'(pmod_cs_o));
    check_value("pmod_copi_o", 32'(v.en[`INOUT_PIN_PMOD1_2] ? v.io[`INOUT_PIN_PMOD1_2] : 1'b1),
                32'(pmod_copi_o));
    check_value("pmod_sck_o", 32'(v.en[`INOUT_PIN_PMOD1_4] ? v.io[`INOUT_PIN_PMOD1_4] : 1'b1),
                32'(pmod_sck_o));
    check_value("i2c_scl_o", 32'(scl_line(v)), 32'(i2c_scl_o));
    check_value("i2c_sda_o", 32'(sda_line(v)), 32'(i2c_sda_o));
    check_value("in_from_pins_o", 32'(exp_in_rd(v, p)), 32'(in_from_pins_o));
    check_value("inout_from_pins_o", 32'(exp_inout_rd(v, p)), 32'(inout_from_pins_o));
    check_value("cheri_seen_o", 32'(seen), 32'(cheri_seen_o));
    check_value("cheri_new_o", 32'(fresh), 32'(cheri_new_o));
  endtask

  initial begin
    vec_t prev;
    board_pkg::cheri_err_t seen_m, new_m;
    prev = '0;
    seen_m = '0;
    new_m = '0;
    rst_ni = 1'b0;
    apply_vec('0);
    build_table();
    cycle_limit = 2 * vec_q.size() + 50;
    repeat (2) @(posedge clk_i);
    for (int k = 0; k < vec_q.size(); k++) begin
      @(negedge clk_i);
      // Reset lifts together with the first row, so no edge has cleared the registers yet.
      if (k == 0) begin
        rst_ni = 1'b1;
      end
      cur_grp = grp_q[k];
      apply_vec(vec_q[k]);
      #1;
      // Registered outputs still show the row before, or reset values for the first.
      check_vec(vec_q[k], prev, seen_m, new_m);
      new_m = vec_q[k].err & ~seen_m;
      seen_m = seen_m | vec_q[k].err;
      prev = vec_q[k];
      grp_vecs[cur_grp] = grp_vecs[cur_grp] + 1;
      if (k == vec_q.size() - 1 || grp_q[k + 1] != cur_grp) begin
        $display("Test %0d, %s: %0d rows, %0d mismatches, %s", cur_grp + 1,
                 test_name(cur_grp), grp_vecs[cur_grp], grp_errs[cur_grp],
                 (grp_errs[cur_grp] == 0) ? "pass" : "fail");
      end
    end
    $display("Checks: %0d, mismatches: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/board_harness_top.sv */
////////////////////////////////////////
// Top of the board pin harness.
// Sits between the SoC pin vectors and the device models.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module board_harness_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // SoC pin vectors.
  input  wire board_pkg::out_pins_t   out_to_pins_i,
  input  wire board_pkg::inout_pins_t inout_to_pins_i,
  input  wire board_pkg::inout_pins_t inout_to_pins_en_i,
  input  wire logic                   rs485_tx_enable_i,
  input  wire logic                   rs485_rx_enable_i,
  output board_pkg::in_pins_t         in_from_pins_o,
  output board_pkg::inout_pins_t      inout_from_pins_o,
  // System UART.
  input  wire logic                   uart_rx_i,
  output logic                        uart_tx_o,
  // RS485 line.
  input  wire logic                   rs485_line_rx_i,
  output logic                        rs485_line_tx_o,
  // Application SPI flash.
  input  wire logic                   flash_cipo_i,
  output logic                        flash_sck_o,
  output logic                        flash_cs_o,
  output logic                        flash_copi_o,
  // PMOD1 SPI device.
  input  wire logic                   pmod_cipo_i,
  output logic                        pmod_sck_o,
  output logic                        pmod_cs_o,
  output logic                        pmod_copi_o,
  // I2C buses.
  input  wire board_pkg::i2c_lines_t  i2c_scl_dev_i,
  input  wire board_pkg::i2c_lines_t  i2c_sda_dev_i,
  output board_pkg::i2c_lines_t       i2c_scl_o,
  output board_pkg::i2c_lines_t       i2c_sda_o,
  // CHERI error tracking.
  input  wire board_pkg::cheri_err_t  cheri_err_i,
  output board_pkg::cheri_err_t       cheri_seen_o,
  output board_pkg::cheri_err_t       cheri_new_o
);

  // Read-pin contributions, each with only its own bits set.
  board_pkg::inout_pins_t router_inout_rd;
  board_pkg::inout_pins_t i2c_inout_rd;

  pin_router pin_router_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .out_to_pins_i      (out_to_pins_i),
    .inout_to_pins_i    (inout_to_pins_i),
    .inout_to_pins_en_i (inout_to_pins_en_i),
    .rs485_tx_enable_i  (rs485_tx_enable_i),
    .rs485_rx_enable_i  (rs485_rx_enable_i),
    .in_from_pins_o     (in_from_pins_o),
    .inout_from_pins_o  (router_inout_rd),
    .uart_rx_i          (uart_rx_i),
    .uart_tx_o          (uart_tx_o),
    .rs485_line_rx_i    (rs485_line_rx_i),
    .rs485_line_tx_o    (rs485_line_tx_o),
    .flash_cipo_i       (flash_cipo_i),
    .flash_sck_o        (flash_sck_o),
    .flash_cs_o         (flash_cs_o),
    .flash_copi_o       (flash_copi_o),
    .pmod_cipo_i        (pmod_cipo_i),
    .pmod_sck_o         (pmod_sck_o),
    .pmod_cs_o          (pmod_cs_o),
    .pmod_copi_o        (pmod_copi_o)
  );

  i2c_bus_fabric i2c_bus_fabric_i (
    .inout_to_pins_i    (inout_to_pins_i),
    .inout_to_pins_en_i (inout_to_pins_en_i),
    .i2c_scl_dev_i      (i2c_scl_dev_i),
    .i2c_sda_dev_i      (i2c_sda_dev_i),
    .i2c_scl_o          (i2c_scl_o),
    .i2c_sda_o          (i2c_sda_o),
    .inout_from_pins_o  (i2c_inout_rd)
  );

  cheri_err_monitor cheri_err_monitor_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cheri_err_i  (cheri_err_i),
    .cheri_seen_o (cheri_seen_o),
    .cheri_new_o  (cheri_new_o)
  );

  // The two owners never share a bit, so OR is a plain merge.
  assign inout_from_pins_o = router_inout_rd | i2c_inout_rd;

endmodule

`default_nettype wire

/* hdl/cheri_err_monitor.sv */
////////////////////////////////////////
// Sticky record of CHERI error kinds.
// Pulses each kind once, on its first occurrence.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cheri_err_monitor (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire board_pkg::cheri_err_t cheri_err_i,
  output board_pkg::cheri_err_t      cheri_seen_o,
  output board_pkg::cheri_err_t      cheri_new_o
);

  board_pkg::cheri_err_t seen_q;
  board_pkg::cheri_err_t new_q;
  // Kinds raised now that were never raised before.
  board_pkg::cheri_err_t first_hit;

  // The error lines drive LEDs and are modulated.
  // A kind repeats many times, so only the first rise counts.
  assign first_hit = cheri_err_i & ~seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q <= '0;
      new_q  <= '0;
    end else begin
      // Accumulate, never clear outside reset.
      seen_q <= seen_q | cheri_err_i;
      // One cycle pulse per kind.
      new_q  <= first_hit;
    end
  end

  assign cheri_seen_o = seen_q;
  assign cheri_new_o  = new_q;

endmodule

`default_nettype wire

/* hdl/i2c_bus_fabric.sv */
////////////////////////////////////////
// Open-drain resolution of the modelled I2C buses.
// Fills the I2C read pins, unmodelled ones read high.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "board_config.svh"

module i2c_bus_fabric (
  input  wire board_pkg::inout_pins_t inout_to_pins_i,
  input  wire board_pkg::inout_pins_t inout_to_pins_en_i,
  // Pull-downs from the device models.
  input  wire board_pkg::i2c_lines_t  i2c_scl_dev_i,
  input  wire board_pkg::i2c_lines_t  i2c_sda_dev_i,
  // Controller drive towards the devices.
  output board_pkg::i2c_lines_t       i2c_scl_o,
  output board_pkg::i2c_lines_t       i2c_sda_o,
  output board_pkg::inout_pins_t      inout_from_pins_o
);

  // Per-bus drive and enable gathered from the pin vectors.
  board_pkg::i2c_lines_t scl_drv, scl_en;
  board_pkg::i2c_lines_t sda_drv, sda_en;
  // Resolved bus levels.
  board_pkg::i2c_lines_t scl_bus, sda_bus;

  always_comb begin
    // HAT ID EEPROM bus.
    scl_drv[`I2C_BUS_HAT_ID] = inout_to_pins_i[`INOUT_PIN_RPH_G1];
    scl_en[`I2C_BUS_HAT_ID]  = inout_to_pins_en_i[`INOUT_PIN_RPH_G1];
    sda_drv[`I2C_BUS_HAT_ID] = inout_to_pins_i[`INOUT_PIN_RPH_G0];
    sda_en[`I2C_BUS_HAT_ID]  = inout_to_pins_en_i[`INOUT_PIN_RPH_G0];
    // HAT secondary bus, shared with GPIO2/3.
    scl_drv[`I2C_BUS_HAT_SEC] = inout_to_pins_i[`INOUT_PIN_RPH_G3_SCL];
    scl_en[`I2C_BUS_HAT_SEC]  = inout_to_pins_en_i[`INOUT_PIN_RPH_G3_SCL];
    sda_drv[`I2C_BUS_HAT_SEC] = inout_to_pins_i[`INOUT_PIN_RPH_G2_SDA];
    sda_en[`I2C_BUS_HAT_SEC]  = inout_to_pins_en_i[`INOUT_PIN_RPH_G2_SDA];
    // QWIIC1 connector.
    scl_drv[`I2C_BUS_QWIIC1] = inout_to_pins_i[`INOUT_PIN_SCL1];
    scl_en[`I2C_BUS_QWIIC1]  = inout_to_pins_en_i[`INOUT_PIN_SCL1];
    sda_drv[`I2C_BUS_QWIIC1] = inout_to_pins_i[`INOUT_PIN_SDA1];
    sda_en[`I2C_BUS_QWIIC1]  = inout_to_pins_en_i[`INOUT_PIN_SDA1];
  end

  // A line is pulled low only when enabled and driven to zero.
  assign i2c_scl_o = ~scl_en | scl_drv;
  assign i2c_sda_o = ~sda_en | sda_drv;

  // Wired AND with the devices.
  // The controller must see its own traffic on the bus, or it flags contention.
  assign scl_bus = i2c_scl_o & i2c_scl_dev_i;
  assign sda_bus = i2c_sda_o & i2c_sda_dev_i;

  always_comb begin
    inout_from_pins_o = '0;
    inout_from_pins_o[`INOUT_PIN_RPH_G1]     = scl_bus[`I2C_BUS_HAT_ID];
    inout_from_pins_o[`INOUT_PIN_RPH_G0]     = sda_bus[`I2C_BUS_HAT_ID];
    inout_from_pins_o[`INOUT_PIN_RPH_G3_SCL] = scl_bus[`I2C_BUS_HAT_SEC];
    inout_from_pins_o[`INOUT_PIN_RPH_G2_SDA] = sda_bus[`I2C_BUS_HAT_SEC];
    inout_from_pins_o[`INOUT_PIN_SCL1]       = scl_bus[`I2C_BUS_QWIIC1];
    inout_from_pins_o[`INOUT_PIN_SDA1]       = sda_bus[`I2C_BUS_QWIIC1];
    // No device on SCL0/SDA0 or the mikroBUS bus, only the board pull-ups.
    inout_from_pins_o[`INOUT_PIN_SCL0] = 1'b1;
    inout_from_pins_o[`INOUT_PIN_SDA0] = 1'b1;
    inout_from_pins_o[`INOUT_PIN_MB5]  = 1'b1;
    inout_from_pins_o[`INOUT_PIN_MB6]  = 1'b1;
  end

endmodule

`default_nettype wire

/* hdl/pin_router.sv */
////////////////////////////////////////
// Routes SoC pins to UART, RS485 and SPI device lines.
// Also holds the registered loopback path.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "board_config.svh"

module pin_router (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // SoC side.
  input  wire board_pkg::out_pins_t   out_to_pins_i,
  input  wire board_pkg::inout_pins_t inout_to_pins_i,
  input  wire board_pkg::inout_pins_t inout_to_pins_en_i,
  input  wire logic                   rs485_tx_enable_i,
  input  wire logic                   rs485_rx_enable_i,
  output board_pkg::in_pins_t         in_from_pins_o,
  output board_pkg::inout_pins_t      inout_from_pins_o,
  // System UART.
  input  wire logic                   uart_rx_i,
  output logic                        uart_tx_o,
  // RS485 line.
  input  wire logic                   rs485_line_rx_i,
  output logic                        rs485_line_tx_o,
  // Application SPI flash.
  input  wire logic                   flash_cipo_i,
  output logic                        flash_sck_o,
  output logic                        flash_cs_o,
  output logic                        flash_copi_o,
  // SPI device on PMOD1.
  input  wire logic                   pmod_cipo_i,
  output logic                        pmod_sck_o,
  output logic                        pmod_cs_o,
  output logic                        pmod_copi_o
);

  // Gathered loopback sources and their registered copy.
  logic [`LOOPBACK_WIDTH-1:0] loopback_d;
  logic [`LOOPBACK_WIDTH-1:0] loopback_q;

  // RS485 receive as seen by the SoC.
  logic rs485_rx;

  // System UART goes straight through.
  assign uart_tx_o = out_to_pins_i[`OUT_PIN_SER0_TX];

  // Transmit idles high while the driver is off.
  assign rs485_line_tx_o = rs485_tx_enable_i ? out_to_pins_i[`OUT_PIN_RS485_TX] : 1'b1;

  // Receiver output reads low while the receiver is off.
  assign rs485_rx = rs485_rx_enable_i ? rs485_line_rx_i : 1'b0;

  // Flash lines have dedicated output pins.
  assign flash_sck_o  = out_to_pins_i[`OUT_PIN_APPSPI_SCK];
  assign flash_cs_o   = out_to_pins_i[`OUT_PIN_APPSPI_CS];
  assign flash_copi_o = out_to_pins_i[`OUT_PIN_APPSPI_COPI];

  // PMOD1 lines are shared pins.
  // Each one floats high on the board unless its enable is set.
  assign pmod_cs_o = inout_to_pins_en_i[`INOUT_PIN_PMOD1_1] ?
                     inout_to_pins_i[`INOUT_PIN_PMOD1_1] : 1'b1;
  assign pmod_copi_o = inout_to_pins_en_i[`INOUT_PIN_PMOD1_2] ?
                       inout_to_pins_i[`INOUT_PIN_PMOD1_2] : 1'b1;
  assign pmod_sck_o = inout_to_pins_en_i[`INOUT_PIN_PMOD1_4] ?
                      inout_to_pins_i[`INOUT_PIN_PMOD1_4] : 1'b1;

  // Loopback sources, most significant first.
  // TMPIO8 to TMPIO9, TMPIO1 to TMPIO0, MB10 PWM to PMOD0_1.
  // MB7 UART TX to MB8, MB4 SPI COPI to MB3.
  assign loopback_d = {
    inout_to_pins_i[`INOUT_PIN_AH_TMPIO8],
    inout_to_pins_i[`INOUT_PIN_AH_TMPIO1],
    out_to_pins_i[`OUT_PIN_MB10],
    out_to_pins_i[`OUT_PIN_MB7],
    out_to_pins_i[`OUT_PIN_MB4]
  };

  // One register stage breaks the loop from output pins back to read pins.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loopback_q <= '0;
    end else begin
      loopback_q <= loopback_d;
    end
  end

  // Read pins owned here.
  // All other bits stay zero so the top level can OR them in.
  always_comb begin
    in_from_pins_o = '0;
    in_from_pins_o[`IN_PIN_SER0_RX]     = uart_rx_i;
    in_from_pins_o[`IN_PIN_RS485_RX]    = rs485_rx;
    in_from_pins_o[`IN_PIN_APPSPI_CIPO] = flash_cipo_i;
    in_from_pins_o[`IN_PIN_MB8]         = loopback_q[1];
    in_from_pins_o[`IN_PIN_MB3]         = loopback_q[0];
  end

  always_comb begin
    inout_from_pins_o = '0;
    // Data back from the PMOD1 SPI device.
    inout_from_pins_o[`INOUT_PIN_PMOD1_3]   = pmod_cipo_i;
    inout_from_pins_o[`INOUT_PIN_AH_TMPIO9] = loopback_q[4];
    inout_from_pins_o[`INOUT_PIN_AH_TMPIO0] = loopback_q[3];
    inout_from_pins_o[`INOUT_PIN_PMOD0_1]   = loopback_q[2];
  end

endmodule

`default_nettype wire

/* hdl/board_pkg.sv */
////////////////////////////////////////
// Shared vector types of the board harness.
// Referenced by scoped name from the RTL and the testbench.
////////////////////////////////////////

`default_nettype none

`include "board_config.svh"

package board_pkg;

  // Pins the SoC reads, one bit per pin.
  typedef logic [`BOARD_IN_PINS-1:0] in_pins_t;

  // Pins the SoC drives, one bit per pin.
  typedef logic [`BOARD_OUT_PINS-1:0] out_pins_t;

  // Bidirectional pins.
  // Same shape for the drive, the enable and the read direction.
  typedef logic [`BOARD_INOUT_PINS-1:0] inout_pins_t;

  // One SCL or SDA line per modelled I2C bus.
  typedef logic [`I2C_BUSES-1:0] i2c_lines_t;

  // One bit per CHERI error kind.
  // Bit 0 bounds, 1 tag, 2 seal, 3 to 8 the permit checks.
  typedef logic [`CHERI_ERR_WIDTH-1:0] cheri_err_t;

endpackage

`default_nettype wire

/* include/board_config.svh */
////////////////////////////////////////
// Pin map and fixed widths of the board harness.
// Included by the package and by every RTL block that picks pins by index.
////////////////////////////////////////

`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// Widths of the SoC pin vectors.
`define BOARD_IN_PINS    8
`define BOARD_OUT_PINS   12
`define BOARD_INOUT_PINS 20

// Input pins, read by the SoC.
`define IN_PIN_SER0_RX     0
`define IN_PIN_RS485_RX    1
`define IN_PIN_APPSPI_CIPO 2
`define IN_PIN_MB3         3
`define IN_PIN_MB8         4

// Output pins, driven by the SoC.
`define OUT_PIN_SER0_TX     0
`define OUT_PIN_RS485_TX    1
`define OUT_PIN_APPSPI_SCK  2
`define OUT_PIN_APPSPI_CS   3
`define OUT_PIN_APPSPI_COPI 4
`define OUT_PIN_MB4         5
`define OUT_PIN_MB7         6
`define OUT_PIN_MB10        7

// Bidirectional pins.
// The first six carry the modelled I2C buses.
`define INOUT_PIN_RPH_G0     0
`define INOUT_PIN_RPH_G1     1
`define INOUT_PIN_RPH_G2_SDA 2
`define INOUT_PIN_RPH_G3_SCL 3
`define INOUT_PIN_SCL1       4
`define INOUT_PIN_SDA1       5
`define INOUT_PIN_SCL0       6
`define INOUT_PIN_SDA0       7
`define INOUT_PIN_MB5        8
`define INOUT_PIN_MB6        9
`define INOUT_PIN_PMOD1_1    10
`define INOUT_PIN_PMOD1_2    11
`define INOUT_PIN_PMOD1_3    12
`define INOUT_PIN_PMOD1_4    13
`define INOUT_PIN_PMOD0_1    14
`define INOUT_PIN_AH_TMPIO0  15
`define INOUT_PIN_AH_TMPIO1  16
`define INOUT_PIN_AH_TMPIO8  17
`define INOUT_PIN_AH_TMPIO9  18

// Modelled I2C buses and their position in the bus vectors.
`define I2C_BUSES       3
`define I2C_BUS_HAT_ID  0
`define I2C_BUS_HAT_SEC 1
`define I2C_BUS_QWIIC1  2

// Other fixed widths.
`define CHERI_ERR_WIDTH 9
`define LOOPBACK_WIDTH  5

`endif
